// File: chipsetRegisterBridge.f
logic/chipsetBusPkg.sv
logic/colorClockPkg.sv
logic/colorClockTracker.sv
logic/registerSpaceDecode.sv
logic/registerDataPath.sv
logic/registerCycleSequencer.sv
logic/chipsetRegisterBridge.sv
test/chipsetRegisterBridgeTb.sv

// File: runSim.sh
#!/bin/sh
# Verilator build and run of the chipset register bridge testbench
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module chipsetRegisterBridgeTb \
    -f chipsetRegisterBridge.f \
    -o chipsetRegisterBridgeTb

# Simulation status is taken from the log, not the exit code
./obj_dir/chipsetRegisterBridgeTb > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: test/chipsetRegisterBridgeTb.sv
/* Directed testbench for the chipset register bridge, colour clock
   generator, Agnus model, compare tasks and the test sequence */

`timescale 1ns/1ps

module chipsetRegisterBridgeTb;
    import chipsetBusPkg::*;

    localparam logic [regBaseWidth-1:0] windowBase = 15'h6FF8;    // 0xDFF000
    localparam int waitLimit = 200;    // Clocks allowed for any wait

    logic         CLK40 = 1'b0;
    logic         nRESET;
    logic         C1 = 1'b1;
    logic         C3 = 1'b0;
    logic         cpuAs;
    cpuAddrT      cpuAddr;
    logic         rnW;
    transferSizeT size;
    chipDataT     cpuWriteData;
    logic         nDbr;
    logic         casAgnus;
    chipDataT     chipDataIn = '0;
    logic         nAs;
    logic         nLds;
    logic         nUds;
    logic         nRegEn;
    logic         regTa;
    chipDataT     cpuReadData;
    chipDataT     chipDataOut;
    logic         chipDataOe;
    regOffsetT    regOffset;

    integer     seed;
    int         colourCount = 0;
    int         writeCount = 0;     // Write samples seen by the Agnus model
    int         writesAtStart;
    chipDataT   writeData;
    logic [1:0] writeLanes;         // {nUds, nLds} with the write data

    chipsetRegisterBridge #(.regBase(windowBase)) UUT (
        .CLK40(CLK40), .nRESET(nRESET), .C1(C1), .C3(C3),
        .cpuAs(cpuAs), .cpuAddr(cpuAddr), .rnW(rnW), .size(size),
        .cpuWriteData(cpuWriteData), .nDbr(nDbr), .casAgnus(casAgnus),
        .chipDataIn(chipDataIn), .nAs(nAs), .nLds(nLds), .nUds(nUds),
        .nRegEn(nRegEn), .regTa(regTa), .cpuReadData(cpuReadData),
        .chipDataOut(chipDataOut), .chipDataOe(chipDataOe), .regOffset(regOffset)
    );

    always #5 CLK40 = ~CLK40;    // 100 MHz in simulation, period 10 ns

    ///////////////////////////////////////////////////////////////////////
    // Colour clock and Agnus model
    ///////////////////////////////////////////////////////////////////////

    // 12 clocks per period, C3 a quarter period behind C1
    always @(posedge CLK40) begin
        #1;
        colourCount = (colourCount == 11) ? 0 : colourCount + 1;
        C1 = (colourCount < 6);
        C3 = (colourCount >= 3) && (colourCount < 9);
    end

    // Fresh read word every clock of a read cycle
    always @(posedge CLK40) begin
        #1;
        if (!nAs && rnW) begin
            chipDataIn = chipDataT'($random(seed));
        end
    end

    // Latch what the bridge drives while a lane is strobed
    always @(negedge CLK40) begin
        if (chipDataOe && (!nUds || !nLds)) begin
            writeCount = writeCount + 1;
            writeData  = chipDataOut;
            writeLanes = {nUds, nLds};
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Compare tasks
    ///////////////////////////////////////////////////////////////////////

    task automatic stopOnFailure();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkData(input string what, input chipDataT got, input chipDataT exp);
        if (got !== exp) begin
            $display("ERR %0t: %s, got %h, expected %h", $time, what, got, exp);
            stopOnFailure();
        end
    endtask

    task automatic checkLanes(input string what, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s nUds/nLds, got %b, expected %b", $time, what, got, exp);
            stopOnFailure();
        end
    endtask

    task automatic checkOffset(input string what, input regOffsetT got, input regOffsetT exp);
        if (got !== exp) begin
            $display("ERR %0t: %s, got %h, expected %h", $time, what, got, exp);
            stopOnFailure();
        end
    endtask

    task automatic checkLevel(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s, got %b, expected %b", $time, what, got, exp);
            stopOnFailure();
        end
    endtask

    // Byte lanes from size and address bit 0, active low
    function automatic logic [1:0] expectedLanes(input logic lsb, input transferSizeT sz);
        logic upperActive;
        logic lowerActive;
        upperActive = !lsb;                        // Even byte, D15..D8
        lowerActive = (sz == sizeWord) || lsb;     // Odd byte or full word
        return {!upperActive, !lowerActive};
    endfunction

    task automatic idleCheck(input string stage);
        checkLevel({stage, " nAs"}, nAs, 1'b1);
        checkLevel({stage, " nRegEn"}, nRegEn, 1'b1);
        checkLanes(stage, {nUds, nLds}, 2'b11);
        checkLevel({stage, " regTa"}, regTa, 1'b0);
        checkLevel({stage, " chipDataOe"}, chipDataOe, 1'b0);
    endtask

    ///////////////////////////////////////////////////////////////////////
    // CPU access
    ///////////////////////////////////////////////////////////////////////

    task automatic startAccess(input cpuAddrT addr, input logic readNotWrite,
                               input transferSizeT sz, input chipDataT data);
        @(posedge CLK40);
        #1;
        cpuAs         = 1'b1;
        cpuAddr       = addr;
        rnW           = readNotWrite;
        size          = sz;
        cpuWriteData  = data;
        writesAtStart = writeCount;
    endtask

    // Wait for regTa, check the cycle, then release like the CPU
    task automatic finishAccess();
        int         cycles;
        int         i;
        logic [1:0] lanes;
        chipDataT   expRead;
        chipDataT   expWrite;
        cycles   = 0;
        lanes    = expectedLanes(cpuAddr[0], size);
        // Lower lane always carries the low byte, upper lane repeats it for a byte
        expWrite = {(size == sizeWord) ? cpuWriteData[15:8] : cpuWriteData[7:0],
                    cpuWriteData[7:0]};
        @(negedge CLK40);
        while (regTa !== 1'b1) begin
            cycles = cycles + 1;
            if (cycles > waitLimit) begin
                $display("Timeout waiting for regTa, address %h", cpuAddr);
                stopOnFailure();
            end
            @(negedge CLK40);
        end
        checkLevel("nAs in acknowledge clock", nAs, 1'b0);
        checkLevel("nRegEn in acknowledge clock", nRegEn, 1'b0);
        checkLanes("Data strobes", {nUds, nLds}, lanes);
        checkOffset("Register offset", regOffset, cpuAddr[regOffsetWidth-1:0]);
        checkLevel("chipDataOe in acknowledge clock", chipDataOe, !rnW);
        expRead = chipDataIn;                     // Word on the bus at S6
        @(posedge CLK40);
        #1;
        cpuAs = 1'b0;
        for (i = 0; i < 12; i++) begin            // One colour clock of quiet bus
            @(negedge CLK40);
            idleCheck("After regTa");
        end
        if (rnW) begin
            checkData("Read data", cpuReadData, expRead);
        end else begin
            if (writeCount == writesAtStart) begin
                $display("No write data seen on the chipset bus, address %h", cpuAddr);
                stopOnFailure();
            end
            checkData("Write data", writeData, expWrite);
            checkLanes("Write lanes", writeLanes, lanes);
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Directed tests
    ///////////////////////////////////////////////////////////////////////

    task automatic resetIdleTest();
        int i;
        for (i = 0; i < 30; i++) begin
            @(negedge CLK40);
            idleCheck("After reset");
        end
    endtask

    task automatic wordReadTest();
        startAccess({windowBase, 9'h01C}, 1'b1, sizeWord, 16'h0000);    // INTENAR
        finishAccess();
    endtask

    task automatic writeLaneTest();
        startAccess({windowBase, 9'h096}, 1'b0, sizeWord, 16'hA55A);
        finishAccess();
        startAccess({windowBase, 9'h09A}, 1'b0, sizeByte, 16'h12C3);    // Upper lane
        finishAccess();
        startAccess({windowBase, 9'h09B}, 1'b0, sizeByte, 16'h7E81);    // Lower lane
        finishAccess();
    endtask

    // Agnus holds the bus for four colour clock periods
    task automatic agnusHoldTest(input logic useCas);
        int i;
        @(posedge CLK40);
        #1;
        nDbr     = useCas;
        casAgnus = useCas;
        startAccess({windowBase, 9'h180}, useCas ? 1'b0 : 1'b1, sizeWord, 16'h0F35);
        for (i = 0; i < 48; i++) begin
            @(negedge CLK40);
            checkLevel("regTa while Agnus holds", regTa, 1'b0);
        end
        checkLevel("nAs while Agnus holds", nAs, 1'b0);
        @(posedge CLK40);
        #1;
        nDbr     = 1'b1;
        casAgnus = 1'b0;
        finishAccess();
    endtask

    task automatic outsideWindowTest();
        int i;
        startAccess(24'hBFE001, 1'b1, sizeByte, 16'h0000);    // CIA space
        for (i = 0; i < 100; i++) begin
            @(negedge CLK40);
            idleCheck("Outside window");
        end
        @(posedge CLK40);
        #1;
        cpuAs = 1'b0;
    endtask

    task automatic backToBackTest();
        int           i;
        regOffsetT    offset;
        logic         readNotWrite;
        transferSizeT sz;
        chipDataT     data;
        for (i = 0; i < 20; i++) begin
            offset       = regOffsetT'($random(seed));
            readNotWrite = ($random(seed) & 1) != 0;
            sz           = (($random(seed) & 1) != 0) ? sizeWord : sizeByte;
            data         = chipDataT'($random(seed));
            if (sz == sizeWord) begin
                offset[0] = 1'b0;    // Words stay aligned
            end
            startAccess({windowBase, offset}, readNotWrite, sz, data);
            finishAccess();
        end
    endtask

    initial begin
        seed         = 32'ha4222ff1;
        nRESET       = 1'b0;
        cpuAs        = 1'b0;
        cpuAddr      = '0;
        rnW          = 1'b1;
        size         = sizeWord;
        cpuWriteData = '0;
        nDbr         = 1'b1;
        casAgnus     = 1'b0;
        repeat (8) @(posedge CLK40);
        #1;
        nRESET = 1'b1;

        resetIdleTest();
        wordReadTest();
        writeLaneTest();
        agnusHoldTest(1'b0);    // nDbr low
        agnusHoldTest(1'b1);    // CAS from Agnus
        outsideWindowTest();
        backToBackTest();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: logic/chipsetRegisterBridge.sv
/* Top level of the CPU to chipset register bridge,
   colour clock tracking, decode, sequencer and datapath */

`timescale 1ns/1ps

module chipsetRegisterBridge #(
    parameter logic [chipsetBusPkg::regBaseWidth-1:0] regBase = 15'h6FF8    // 0xDFF000
) (
    input  logic                        CLK40,
    input  logic                        nRESET,
    input  logic                        C1,
    input  logic                        C3,
    input  logic                        cpuAs,
    input  chipsetBusPkg::cpuAddrT      cpuAddr,
    input  logic                        rnW,
    input  chipsetBusPkg::transferSizeT size,
    input  chipsetBusPkg::chipDataT     cpuWriteData,
    input  logic                        nDbr,
    input  logic                        casAgnus,
    input  chipsetBusPkg::chipDataT     chipDataIn,
    output logic                        nAs,
    output logic                        nLds,
    output logic                        nUds,
    output logic                        nRegEn,
    output logic                        regTa,
    output chipsetBusPkg::chipDataT     cpuReadData,
    output chipsetBusPkg::chipDataT     chipDataOut,
    output logic                        chipDataOe,
    output chipsetBusPkg::regOffsetT    regOffset
);

    logic phaseStart;
    logic phaseData;
    logic phaseAck;
    logic regSelect;
    logic asEn;
    logic dsEn;
    logic regEn;
    logic ackPulse;

    ///////////////////////////////////////////////////////////////////////
    // Control
    ///////////////////////////////////////////////////////////////////////

    colorClockTracker clockTracker (
        .CLK40(CLK40), .nRESET(nRESET), .C1(C1), .C3(C3),
        .phaseStart(phaseStart), .phaseData(phaseData), .phaseAck(phaseAck)
    );

    registerSpaceDecode #(.regBase(regBase)) spaceDecode (
        .CLK40(CLK40), .nRESET(nRESET), .cpuAs(cpuAs), .cpuAddr(cpuAddr),
        .regSelect(regSelect), .regOffset(regOffset)
    );

    registerCycleSequencer cycleSequencer (
        .CLK40(CLK40), .nRESET(nRESET),
        .phaseStart(phaseStart), .phaseData(phaseData), .phaseAck(phaseAck),
        .regSelect(regSelect), .rnW(rnW), .nDbr(nDbr), .casAgnus(casAgnus),
        .asEn(asEn), .dsEn(dsEn), .regEn(regEn), .ackPulse(ackPulse)
    );

    ///////////////////////////////////////////////////////////////////////
    // Datapath
    ///////////////////////////////////////////////////////////////////////

    registerDataPath dataPath (
        .CLK40(CLK40), .nRESET(nRESET),
        .dsEn(dsEn), .regEn(regEn), .ackPulse(ackPulse),
        .rnW(rnW), .size(size), .addrLsb(cpuAddr[0]),
        .cpuWriteData(cpuWriteData), .chipDataIn(chipDataIn),
        .nLds(nLds), .nUds(nUds), .chipDataOut(chipDataOut),
        .chipDataOe(chipDataOe), .cpuReadData(cpuReadData)
    );

    assign nAs    = ~asEn;     // Active low to the chipset
    assign nRegEn = ~regEn;    // Register buffer enable
    assign regTa  = ackPulse;  // Transfer acknowledge back to the CPU

endmodule

// File: logic/registerCycleSequencer.sv
/* Register cycle sequencer, orders a 68000 style chipset
   register cycle on the colour clock with Agnus precedence */

`timescale 1ns/1ps

module registerCycleSequencer (
    input  logic CLK40,
    input  logic nRESET,
    input  logic phaseStart,    // S2 point
    input  logic phaseData,     // S4 point
    input  logic phaseAck,      // S6 point
    input  logic regSelect,
    input  logic rnW,
    input  logic nDbr,          // Agnus owns the bus when low
    input  logic casAgnus,      // Agnus chip RAM cycle in progress
    output logic asEn,
    output logic dsEn,
    output logic regEn,
    output logic ackPulse       // One clock, becomes regTa
);
    import colorClockPkg::*;

    busStateT state;
    logic     agnusFree;

    // Agnus always wins, both conditions must be gone
    assign agnusFree = nDbr && !casAgnus;

    ///////////////////////////////////////////////////////////////////////
    // Cycle state machine
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            state    <= waitStart;
            asEn     <= 1'b0;
            dsEn     <= 1'b0;
            regEn    <= 1'b0;
            ackPulse <= 1'b0;
        end else begin
            case (state)

                waitStart: begin
                    // Only start on a colour clock boundary
                    if (phaseStart && regSelect) begin
                        asEn  <= 1'b1;
                        regEn <= 1'b1;
                        dsEn  <= rnW;              // Reads strobe together with AS
                        state <= waitData;
                    end
                end

                waitData: begin
                    if (phaseData) begin
                        dsEn <= 1'b1;              // Write strobes come in late
                        if (agnusFree) begin
                            state <= waitAck;
                        end
                        // Otherwise one more colour clock period of wait
                    end
                end

                waitAck: begin
                    if (phaseAck) begin
                        ackPulse <= 1'b1;
                        state    <= endCycle;
                    end
                end

                endCycle: begin
                    ackPulse <= 1'b0;
                    asEn     <= 1'b0;
                    dsEn     <= 1'b0;
                    regEn    <= 1'b0;
                    // Re-align before the next S2
                    if (phaseData) begin
                        state <= waitStart;
                    end
                end

                default: begin
                    state <= waitStart;
                end

            endcase
        end
    end

endmodule

// File: logic/registerDataPath.sv
/* Register cycle datapath, byte lane strobes, write
   data hold with output enable and read data capture */

`timescale 1ns/1ps

module registerDataPath (
    input  logic                        CLK40,
    input  logic                        nRESET,
    input  logic                        dsEn,        // Data strobe window
    input  logic                        regEn,       // Register buffers on
    input  logic                        ackPulse,    // S6 acknowledge
    input  logic                        rnW,
    input  chipsetBusPkg::transferSizeT size,
    input  logic                        addrLsb,
    input  chipsetBusPkg::chipDataT     cpuWriteData,
    input  chipsetBusPkg::chipDataT     chipDataIn,
    output logic                        nLds,
    output logic                        nUds,
    output chipsetBusPkg::chipDataT     chipDataOut,
    output logic                        chipDataOe,
    output chipsetBusPkg::chipDataT     cpuReadData
);
    import chipsetBusPkg::*;

    chipDataT writeWord;

    ///////////////////////////////////////////////////////////////////////
    // Byte lanes
    ///////////////////////////////////////////////////////////////////////

    // Even byte on the upper lane, odd byte on the lower lane
    assign nUds = ~(dsEn && !addrLsb);
    assign nLds = ~(dsEn && ((size == sizeWord) || addrLsb));

    ///////////////////////////////////////////////////////////////////////
    // Write path
    ///////////////////////////////////////////////////////////////////////

    // A byte goes out on both halves, the strobes pick the lane
    assign writeWord = (size == sizeByte) ? {2{cpuWriteData[chipDataWidth/2-1:0]}}
                                          : cpuWriteData;

    // Tracks the CPU until the cycle opens, then frozen for the cycle
    always_ff @(posedge CLK40) begin
        if (!regEn) begin
            chipDataOut <= writeWord;
        end
    end

    assign chipDataOe = regEn && !rnW;    // Drive only inside a write cycle

    ///////////////////////////////////////////////////////////////////////
    // Read path
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            cpuReadData <= '0;
        end else if (ackPulse) begin
            cpuReadData <= chipDataIn;    // Sampled at the S6 point
        end
    end

endmodule

// File: logic/registerSpaceDecode.sv
/* Register window decode, registered select level
   and the offset driven to the chipset address lines */

`timescale 1ns/1ps

module registerSpaceDecode #(
    parameter logic [chipsetBusPkg::regBaseWidth-1:0] regBase = 15'h6FF8    // 0xDFF000
) (
    input  logic                     CLK40,
    input  logic                     nRESET,
    input  logic                     cpuAs,        // High for the whole access
    input  chipsetBusPkg::cpuAddrT   cpuAddr,
    output logic                     regSelect,    // Access hits the window
    output chipsetBusPkg::regOffsetT regOffset
);
    import chipsetBusPkg::*;

    logic windowHit;

    // Upper address bits against the window base
    assign windowHit = (cpuAddr[cpuAddrWidth-1:regOffsetWidth] == regBase);

    // Select only counts while the CPU strobe is up
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            regSelect <= 1'b0;
        end else begin
            regSelect <= cpuAs && windowHit;
        end
    end

    // Offset follows the address, stable while cpuAs is held
    always_ff @(posedge CLK40) begin
        regOffset <= cpuAddr[regOffsetWidth-1:0];
    end

endmodule

// File: logic/colorClockTracker.sv
/* Colour clock tracker, synchronizes C1 and C3 and
   pulses at the 68000 state 2, 4 and 6 points */

`timescale 1ns/1ps

module colorClockTracker (
    input  logic CLK40,
    input  logic nRESET,
    input  logic C1,
    input  logic C3,
    output logic phaseStart,    // S2 point
    output logic phaseData,     // S4 point
    output logic phaseAck       // S6 point
);
    import colorClockPkg::*;

    logic [syncDepth:0] c1Sync;    // Low bits synchronize, top bit is history
    logic [syncDepth:0] c3Sync;
    logic c1Now;
    logic c1Was;
    logic c3Now;
    logic c3Was;

    assign c1Now = c1Sync[syncDepth-1];
    assign c1Was = c1Sync[syncDepth];
    assign c3Now = c3Sync[syncDepth-1];
    assign c3Was = c3Sync[syncDepth];

    ///////////////////////////////////////////////////////////////////////
    // Synchronizers, idle high like the chipset clocks at power up
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            c1Sync <= '1;
            c3Sync <= '1;
        end else begin
            c1Sync <= {c1Sync[syncDepth-1:0], C1};
            c3Sync <= {c3Sync[syncDepth-1:0], C3};
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Phase points, edge of one clock with the other one steady
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            phaseStart <= 1'b0;
            phaseData  <= 1'b0;
            phaseAck   <= 1'b0;
        end else begin
            phaseStart <= !c1Now && !c1Was && c3Was && !c3Now;    // C3 falls, C1 low
            phaseData  <= c1Now && c1Was && !c3Was && c3Now;      // C3 rises, C1 high
            phaseAck   <= !c3Now && !c3Was && !c1Was && c1Now;    // C1 rises, C3 low
        end
    end

endmodule

// File: logic/colorClockPkg.sv
/* 68000 bus state names for the register cycle sequencer
   and the colour clock synchronizer depth */

package colorClockPkg;

    // Stages ahead of the edge history bit
    localparam int syncDepth = 2;

    // Sequencer states, named after the 68000 bus state they wait in
    typedef enum logic [1:0] {
        waitStart = 2'b00,    // S2, C1 and C3 low
        waitData  = 2'b01,    // S4, C1 and C3 high
        waitAck   = 2'b10,    // S6, C1 rising
        endCycle  = 2'b11     // S7, strobes negated
    } busStateT;

endpackage

// File: logic/chipsetBusPkg.sv
/* Chipset bus widths, CPU address and data word types,
   register window offset and the CPU transfer size encoding */

package chipsetBusPkg;

    ///////////////////////////////////////////////////////////////////////
    // Widths
    ///////////////////////////////////////////////////////////////////////

    localparam int chipDataWidth  = 16;    // 68000-style register bus
    localparam int cpuAddrWidth   = 24;    // Chipset-visible byte address
    localparam int regOffsetWidth = 9;     // 512-byte register window

    // Upper address bits compared against the window base
    localparam int regBaseWidth   = cpuAddrWidth - regOffsetWidth;

    ///////////////////////////////////////////////////////////////////////
    // Types
    ///////////////////////////////////////////////////////////////////////

    typedef logic [chipDataWidth-1:0]  chipDataT;     // One chipset word
    typedef logic [cpuAddrWidth-1:0]   cpuAddrT;      // CPU byte address
    typedef logic [regOffsetWidth-1:0] regOffsetT;    // Offset inside window

    // Same coding as the 68k SIZ1:SIZ0 pins
    typedef enum logic [1:0] {
        sizeByte = 2'b01,
        sizeWord = 2'b10
    } transferSizeT;

endpackage
